/* source/isa_pkg.sv */
package isa_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int word_w      = 16;              // data word
    localparam int reg_idx_w   = 4;               // register index
    localparam int num_regs    = 1 << reg_idx_w;  // sixteen architectural regs
    localparam int pc_w        = 11;              // word address, no byte bit
    localparam int imm_w       = 5;               // branch offset
    localparam int opcode_w    = 3;

    // multiplier latency from exec_start to result
    localparam int mult_stages = 2;
    localparam int mult_half_w = word_w / 2;      // operand split for partial products

    typedef logic signed [word_w-1:0] word_t;
    typedef logic [reg_idx_w-1:0]     reg_idx_t;
    typedef logic [pc_w-1:0]          pc_t;
    typedef logic [opcode_w-1:0]      opcode_t;

    // ------------------------------
    // opcodes
    // ------------------------------
    localparam opcode_t op_arith    = 3'b000;     // add / sub by func
    localparam opcode_t op_slt_mult = 3'b001;     // slt / mult by func
    localparam opcode_t op_beq      = 3'b100;     // branch on equal

    // r-type view
    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic     func;   // 0 add/slt, 1 sub/mult
    } instr_r_t;

    // branch view, same rs/rt position
    typedef struct packed {
        opcode_t                 opcode;
        reg_idx_t                rs;
        reg_idx_t                rt;
        logic signed [imm_w-1:0] imm;  // offset from pc+1
    } instr_b_t;

    // one 16-bit instruction word, decoded either way
    typedef union packed {
        instr_r_t r;
        instr_b_t b;
    } instr_u;

    // ------------------------------
    // sequencer states
    // ------------------------------
    localparam logic [1:0] st_idle  = 2'd0;       // halted, waiting for run
    localparam logic [1:0] st_fetch = 2'd1;       // request out, waiting for instr
    localparam logic [1:0] st_exe   = 2'd2;       // decode, branch, issue
    localparam logic [1:0] st_alu   = 2'd3;       // waiting on exec_done

endpackage

/* source/fetch_ctrl.sv */
`timescale 1ns/1ns

module fetch_ctrl
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            run,
    input  logic            instr_valid,
    input  isa_pkg::instr_u instr_data,
    input  isa_pkg::word_t  rs_data,
    input  isa_pkg::word_t  rt_data,
    input  logic            exec_done,
    output logic            fetch_req,
    output isa_pkg::pc_t    fetch_addr,
    output isa_pkg::instr_u instr,
    output logic            exec_start,
    output logic            io_stall
);

    logic [1:0]      state;
    logic [1:0]      state_nxt;
    isa_pkg::instr_u instr_q;
    isa_pkg::pc_t    pc;
    isa_pkg::pc_t    pc_inc;
    isa_pkg::pc_t    br_off;
    isa_pkg::pc_t    pc_nxt;
    logic            is_alu;
    logic            br_taken;
    logic            retire;

    // ------------------------------
    // decode, branch target
    // ------------------------------
    assign is_alu = (instr_q.r.opcode == isa_pkg::op_arith) ||
                    (instr_q.r.opcode == isa_pkg::op_slt_mult);

    // compare straight off the read ports
    assign br_taken = (instr_q.b.opcode == isa_pkg::op_beq) && (rs_data == rt_data);

    assign pc_inc = pc + isa_pkg::pc_t'(1);
    // sign extend imm to pc width
    assign br_off = {{(isa_pkg::pc_w - isa_pkg::imm_w){instr_q.b.imm[isa_pkg::imm_w-1]}},
                     instr_q.b.imm};
    assign pc_nxt = br_taken ? pc_inc + br_off : pc_inc;   // wraps at 11 bits

    // beq and dropped opcodes retire in exe, alu ops on exec_done
    assign retire = ((state == isa_pkg::st_exe) && !is_alu) ||
                    ((state == isa_pkg::st_alu) && exec_done);

    // ------------------------------
    // sequencer
    // ------------------------------
    always_comb
    begin
        state_nxt = state;
        case (state)
            isa_pkg::st_idle:
            begin
                if (run)
                    state_nxt = isa_pkg::st_fetch;
            end
            isa_pkg::st_fetch:
            begin
                if (instr_valid)
                    state_nxt = isa_pkg::st_exe;
            end
            isa_pkg::st_exe:
            begin
                if (is_alu)
                    state_nxt = isa_pkg::st_alu;
                else
                    state_nxt = run ? isa_pkg::st_fetch : isa_pkg::st_idle;
            end
            isa_pkg::st_alu:
            begin
                if (exec_done)
                    state_nxt = run ? isa_pkg::st_fetch : isa_pkg::st_idle;
            end
            default: state_nxt = isa_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= isa_pkg::st_idle;
            fetch_req <= 1'b0;
            pc        <= '0;
        end
        else
        begin
            state     <= state_nxt;
            // single pulse on entry to fetch
            fetch_req <= (state_nxt == isa_pkg::st_fetch) && (state != isa_pkg::st_fetch);
            if (retire)
                pc <= pc_nxt;  // next fetch carries the new pc
        end
    end

    // stray responses outside fetch are dropped
    always_ff @(posedge clk)
    begin
        if ((state == isa_pkg::st_fetch) && instr_valid)
            instr_q <= instr_data;
    end

    assign fetch_addr = pc;                          // stable while waiting
    assign instr      = instr_q;
    assign exec_start = (state == isa_pkg::st_exe);  // cycle after instr_valid
    assign io_stall   = !retire;                     // low one cycle per instruction

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ns

module reg_file
(
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::reg_idx_t rs_idx,
    input  isa_pkg::reg_idx_t rt_idx,
    input  logic              we,
    input  isa_pkg::reg_idx_t wr_idx,
    input  isa_pkg::word_t    wr_data,
    input  logic              host_we,
    input  isa_pkg::reg_idx_t host_idx,
    input  isa_pkg::word_t    host_data,
    output isa_pkg::word_t    rs_data,
    output isa_pkg::word_t    rt_data
);

    // architectural registers r0..r15
    isa_pkg::word_t regs [isa_pkg::num_regs];

    // ------------------------------
    // write side
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < isa_pkg::num_regs; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we)
        begin
            regs[wr_idx] <= wr_data;      // core writeback
        end
        else if (host_we)
        begin
            regs[host_idx] <= host_data;  // preload while halted
        end
    end

    // ------------------------------
    // read side
    // ------------------------------
    // no bypass needed
    // one instruction in flight, writeback lands before the next decode
    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];

endmodule

/* source/exec_unit.sv */
`timescale 1ns/1ns

module exec_unit
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              exec_start,
    input  isa_pkg::instr_u   instr,
    input  isa_pkg::word_t    rs_data,
    input  isa_pkg::word_t    rt_data,
    output logic              exec_done,
    output isa_pkg::reg_idx_t wr_idx,
    output isa_pkg::word_t    wr_data,
    output logic              we
);

    // operand and destination latches
    isa_pkg::word_t    op_a;
    isa_pkg::word_t    op_b;
    isa_pkg::reg_idx_t dst_q;
    isa_pkg::opcode_t  opc_q;
    logic              func_q;

    logic                              simple_start;
    logic                              mult_start;
    logic                              alu_pend;
    logic [isa_pkg::mult_stages-1:0]   mult_pipe;   // valid bit per stage

    logic [isa_pkg::word_w-1:0]      a_u;
    logic [isa_pkg::word_w-1:0]      b_u;
    logic [isa_pkg::word_w-1:0]      pp_lo_d;
    logic [isa_pkg::mult_half_w-1:0] pp_hi_d;
    logic [isa_pkg::word_w-1:0]      pp_lo_q;
    logic [isa_pkg::mult_half_w-1:0] pp_hi_q;

    isa_pkg::word_t sum;
    isa_pkg::word_t diff;
    isa_pkg::word_t slt_res;
    isa_pkg::word_t prod;

    // ------------------------------
    // issue decode
    // ------------------------------
    assign simple_start = exec_start &&
                          ((instr.r.opcode == isa_pkg::op_arith) ||
                           ((instr.r.opcode == isa_pkg::op_slt_mult) && !instr.r.func));
    assign mult_start   = exec_start &&
                          (instr.r.opcode == isa_pkg::op_slt_mult) && instr.r.func;

    always_ff @(posedge clk)
    begin
        if (exec_start)
        begin
            op_a   <= rs_data;
            op_b   <= rt_data;
            dst_q  <= instr.r.rd;
            opc_q  <= instr.r.opcode;
            func_q <= instr.r.func;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            alu_pend  <= 1'b0;
            mult_pipe <= '0;
        end
        else
        begin
            alu_pend  <= simple_start;  // add/sub/slt done next cycle
            mult_pipe <= {mult_pipe[isa_pkg::mult_stages-2:0], mult_start};
        end
    end

    // ------------------------------
    // multiplier
    // ------------------------------
    // low half of signed product equals low half of the raw bit product
    assign a_u = op_a;
    assign b_u = op_b;

    // a x b low byte
    assign pp_lo_d = a_u * {{isa_pkg::mult_half_w{1'b0}},
                            b_u[isa_pkg::mult_half_w-1:0]};
    // only low bits survive shift
    assign pp_hi_d = a_u[isa_pkg::mult_half_w-1:0] *
                     b_u[isa_pkg::word_w-1:isa_pkg::mult_half_w];

    // stage 1 partial products, loaded every cycle
    always_ff @(posedge clk)
    begin
        pp_lo_q <= pp_lo_d;
        pp_hi_q <= pp_hi_d;
    end

    assign prod = pp_lo_q + {pp_hi_q, {isa_pkg::mult_half_w{1'b0}}};  // stage 2 merge

    // ------------------------------
    // alu and writeback select
    // ------------------------------
    assign sum     = op_a + op_b;                                 // wraps
    assign diff    = op_a - op_b;
    assign slt_res = (op_a < op_b) ? isa_pkg::word_t'(1) : '0;  // signed compare

    always_comb
    begin
        if (mult_pipe[isa_pkg::mult_stages-1])
            wr_data = prod;
        else if (opc_q == isa_pkg::op_slt_mult)
            wr_data = slt_res;
        else if (func_q)
            wr_data = diff;
        else
            wr_data = sum;
    end

    assign exec_done = alu_pend || mult_pipe[isa_pkg::mult_stages-1];
    assign we        = exec_done;  // every alu op writes rd
    assign wr_idx    = dst_q;

endmodule

/* source/isa_core.sv */
`timescale 1ns/1ns

module isa_core
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    input  logic              host_we,
    input  isa_pkg::reg_idx_t host_idx,
    input  isa_pkg::word_t    host_data,
    input  logic              instr_valid,
    input  isa_pkg::instr_u   instr_data,
    output logic              fetch_req,
    output isa_pkg::pc_t      fetch_addr,
    output logic              wb_valid,
    output isa_pkg::reg_idx_t wb_idx,
    output isa_pkg::word_t    wb_data,
    output logic              io_stall
);

    isa_pkg::instr_u   instr;       // latched instruction
    logic              exec_start;
    logic              exec_done;
    isa_pkg::word_t    rs_data;
    isa_pkg::word_t    rt_data;
    logic              ex_we;
    isa_pkg::reg_idx_t ex_wr_idx;
    isa_pkg::word_t    ex_wr_data;

    // ------------------------------
    // sequencer
    fetch_ctrl u_fetch_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .instr_valid (instr_valid),
        .instr_data  (instr_data),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .exec_done   (exec_done),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .instr       (instr),
        .exec_start  (exec_start),
        .io_stall    (io_stall)
    );

    // ------------------------------
    // registers, host port only while halted
    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs_idx    (instr.r.rs),
        .rt_idx    (instr.r.rt),
        .we        (ex_we),
        .wr_idx    (ex_wr_idx),
        .wr_data   (ex_wr_data),
        .host_we   (host_we && !run),
        .host_idx  (host_idx),
        .host_data (host_data),
        .rs_data   (rs_data),
        .rt_data   (rt_data)
    );

    exec_unit u_exec_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .exec_start (exec_start),
        .instr      (instr),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .exec_done  (exec_done),
        .wr_idx     (ex_wr_idx),
        .wr_data    (ex_wr_data),
        .we         (ex_we)
    );

    assign wb_valid = ex_we;       // one pulse per register write
    assign wb_idx   = ex_wr_idx;
    assign wb_data  = ex_wr_data;

endmodule

/* dv/isa_ref.svh */
`ifndef ISA_REF_SVH
`define ISA_REF_SVH

// ------------------------------
// reference model, kept instructions only
// ------------------------------

// add/sub/slt/mult write rd, every other opcode retires silently
function automatic bit writes_rd(input isa_pkg::instr_u w);
    return (w.r.opcode == isa_pkg::op_arith) || (w.r.opcode == isa_pkg::op_slt_mult);
endfunction

// value for rd, a from rs and b from rt
function automatic isa_pkg::word_t expected_result(input isa_pkg::instr_u w,
                                                   input isa_pkg::word_t a,
                                                   input isa_pkg::word_t b);
    int sa;
    int sb;
    sa = a;                                                   // sign extended
    sb = b;
    if (w.r.opcode == isa_pkg::op_arith)
        return isa_pkg::word_t'(w.r.func ? sa - sb : sa + sb);  // wraps to 16 bits
    if (!w.r.func)
        return (sa < sb) ? isa_pkg::word_t'(1) : isa_pkg::word_t'(0);
    return isa_pkg::word_t'(sa * sb);                         // low half of the full product
endfunction

// pc+1, plus the offset when a beq sees equal values
function automatic isa_pkg::pc_t next_pc(input isa_pkg::instr_u w,
                                         input isa_pkg::word_t a,
                                         input isa_pkg::word_t b,
                                         input isa_pkg::pc_t pc);
    int target;
    int off;
    off    = $signed(w.b.imm);
    target = int'(pc) + 1;
    if ((w.b.opcode == isa_pkg::op_beq) && (a == b))
        target = target + off;
    return isa_pkg::pc_t'(target);                            // modulo 2048
endfunction

`endif

/* dv/tb_isa_core.sv */
`timescale 1ns/1ns

module tb_isa_core;

    `include "isa_ref.svh"

    localparam int wait_limit = 40;   // cycles allowed for any single wait

    logic              clk = 1'b0;
    logic              rst_n;
    logic              run;
    logic              host_we;
    isa_pkg::reg_idx_t host_idx;
    isa_pkg::word_t    host_data;
    logic              instr_valid;
    isa_pkg::instr_u   instr_data;
    logic              fetch_req;
    isa_pkg::pc_t      fetch_addr;
    logic              wb_valid;
    isa_pkg::reg_idx_t wb_idx;
    isa_pkg::word_t    wb_data;
    logic              io_stall;

    isa_pkg::instr_u prog [1 << isa_pkg::pc_w];   // instruction memory model
    isa_pkg::word_t  model_regs [isa_pkg::num_regs];
    isa_pkg::pc_t    model_pc = '0;
    isa_pkg::pc_t    load_addr;
    isa_pkg::instr_u cur;                         // checker scratch
    isa_pkg::word_t  cur_a;
    isa_pkg::word_t  cur_b;
    bit              pending = 1'b0;              // fetched but not yet retired
    integer          seed = 66;

    isa_core uut (.*);

    always #2 clk = ~clk;

    // ------------------------------
    // error reporting and compares
    // ------------------------------
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input isa_pkg::word_t got,
                              input isa_pkg::word_t exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH time=%0t %s got=%0d exp=%0d",
                                $time, name, got, exp));
    endtask

    task automatic check_idx(input string name, input isa_pkg::reg_idx_t got,
                             input isa_pkg::reg_idx_t exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH time=%0t %s got=%0d exp=%0d",
                                $time, name, got, exp));
    endtask

    task automatic check_pc(input string name, input isa_pkg::pc_t got,
                            input isa_pkg::pc_t exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH time=%0t %s got=%0h exp=%0h",
                                $time, name, got, exp));
    endtask

    // ------------------------------
    // program building
    // ------------------------------
    function automatic isa_pkg::instr_u rtype(input isa_pkg::opcode_t opc, input int rs,
                                              input int rt, input int rd, input bit func);
        isa_pkg::instr_u w;
        w.r.opcode = opc;
        w.r.rs     = isa_pkg::reg_idx_t'(rs);
        w.r.rt     = isa_pkg::reg_idx_t'(rt);
        w.r.rd     = isa_pkg::reg_idx_t'(rd);
        w.r.func   = func;
        return w;
    endfunction

    function automatic isa_pkg::instr_u beq(input int rs, input int rt, input int imm);
        isa_pkg::instr_u w;
        w.b.opcode = isa_pkg::op_beq;
        w.b.rs     = isa_pkg::reg_idx_t'(rs);
        w.b.rt     = isa_pkg::reg_idx_t'(rt);
        w.b.imm    = imm[isa_pkg::imm_w-1:0];   // two's complement offset
        return w;
    endfunction

    task automatic append(input isa_pkg::instr_u w);
        prog[load_addr] = w;
        load_addr       = load_addr + 1'b1;
    endtask

    // host port writes the whole model register array
    task automatic preload_regs();
        for (int i = 0; i < isa_pkg::num_regs; i++)
        begin
            @(posedge clk);
            host_we   <= 1'b1;
            host_idx  <= isa_pkg::reg_idx_t'(i);
            host_data <= model_regs[i];
        end
        @(posedge clk);
        host_we <= 1'b0;
    endtask

    // answer fetches until stop_addr is delivered, then halt
    task automatic run_program(input isa_pkg::pc_t stop_addr);
        int           t;
        int           dly;
        bit           last;
        isa_pkg::pc_t addr;
        last = 1'b0;
        if (pending)
            abort_run("fetch_req seen while the core was halted");
        @(posedge clk);
        run <= 1'b1;
        while (!last)
        begin
            t = 0;
            do
            begin
                @(posedge clk);
                t++;
            end
            while (!fetch_req && (t < wait_limit));
            if (!fetch_req)
                abort_run("timeout waiting for fetch_req");
            addr = fetch_addr;
            dly  = 1 + ($unsigned($random(seed)) % 4);   // 1 to 4 cycles
            repeat (dly - 1) @(posedge clk);
            last         = (addr == stop_addr);
            instr_valid <= 1'b1;
            instr_data  <= prog[addr];
            if (last)
                run <= 1'b0;   // core goes idle at this retirement
            @(posedge clk);
            instr_valid <= 1'b0;
        end
        t = 0;
        while (pending && (t < wait_limit))
        begin
            @(posedge clk);
            t++;
        end
        if (pending)
            abort_run("timeout waiting for the last instruction to retire");
    endtask

    // ------------------------------
    // checker sampled on the rising edge
    // ------------------------------
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (fetch_req)
            begin
                if (pending)
                    abort_run("fetch_req issued before the previous instruction retired");
                check_pc("fetch_addr", fetch_addr, model_pc);
                pending <= 1'b1;
            end
            if (!io_stall)
            begin
                if (!pending)
                    abort_run("io_stall dropped with no instruction in flight");
                cur   = prog[model_pc];
                cur_a = model_regs[cur.r.rs];
                cur_b = model_regs[cur.r.rt];
                if (writes_rd(cur))
                begin
                    if (wb_valid !== 1'b1)
                        abort_run("no wb_valid in the retirement cycle of an alu op");
                    check_idx("wb_idx", wb_idx, cur.r.rd);
                    check_word("wb_data", wb_data, expected_result(cur, cur_a, cur_b));
                    model_regs[cur.r.rd] = expected_result(cur, cur_a, cur_b);
                end
                else if (wb_valid !== 1'b0)
                    abort_run("wb_valid on an instruction that writes no register");
                model_pc = next_pc(cur, cur_a, cur_b, model_pc);
                pending <= 1'b0;
            end
            else if (wb_valid !== 1'b0)
                abort_run("wb_valid outside a retirement cycle");
        end
    end

    initial
    begin
        rst_n       = 1'b0;
        run         = 1'b0;
        host_we     = 1'b0;
        host_idx    = '0;
        host_data   = '0;
        instr_valid = 1'b0;
        instr_data  = '0;
        for (int i = 0; i < (1 << isa_pkg::pc_w); i++)
            prog[i] = {3'b101, i[1:0], i[10:0]};   // no-op fill tagged with its address
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // stray response while halted must be dropped
        @(posedge clk);
        instr_valid <= 1'b1;
        instr_data  <= rtype(isa_pkg::op_arith, 1, 2, 3, 1'b0);
        @(posedge clk);
        instr_valid <= 1'b0;
        repeat (4)
        begin
            @(posedge clk);
            if ((io_stall !== 1'b1) || (fetch_req !== 1'b0) || (wb_valid !== 1'b0))
                abort_run("outputs not idle while halted after reset");
        end

        // ------------------------------
        // program 1 with alu ops, beq and dropped opcodes
        for (int i = 0; i < isa_pkg::num_regs; i++)
            model_regs[i] = isa_pkg::word_t'($random(seed));
        model_regs[1] = 16'h7fff;   // max positive
        model_regs[2] = 16'h0001;
        model_regs[3] = 16'h8000;   // min negative
        model_regs[4] = 16'hffff;
        model_regs[5] = 16'h0005;
        model_regs[6] = 16'hfffb;
        model_regs[7] = 16'h0005;   // same as r5
        model_regs[8] = 16'hff00;
        load_addr = model_pc;
        append(rtype(isa_pkg::op_arith, 1, 2, 9, 1'b0));       // overflow to 8000
        append(rtype(isa_pkg::op_arith, 3, 2, 10, 1'b1));      // underflow to 7fff
        append(rtype(isa_pkg::op_arith, 3, 4, 11, 1'b0));
        append(rtype(isa_pkg::op_arith, 12, 13, 12, 1'b1));    // random operands
        append(rtype(isa_pkg::op_arith, 15, 0, 14, 1'b0));
        append(rtype(isa_pkg::op_slt_mult, 6, 5, 9, 1'b0));    // -5 < 5
        append(rtype(isa_pkg::op_slt_mult, 5, 6, 10, 1'b0));
        append(rtype(isa_pkg::op_slt_mult, 5, 7, 11, 1'b0));   // equal gives 0
        append(rtype(isa_pkg::op_slt_mult, 3, 1, 12, 1'b0));
        append(rtype(isa_pkg::op_slt_mult, 6, 4, 13, 1'b1));   // neg x neg
        append(rtype(isa_pkg::op_slt_mult, 8, 6, 14, 1'b1));
        append(rtype(isa_pkg::op_slt_mult, 1, 1, 15, 1'b1));   // upper half dropped
        append(rtype(isa_pkg::op_slt_mult, 12, 13, 9, 1'b1));
        append(beq(5, 7, 2));                                  // taken and skips two
        append(rtype(isa_pkg::op_arith, 1, 1, 1, 1'b0));
        append(rtype(isa_pkg::op_arith, 2, 2, 2, 1'b0));
        append(beq(5, 6, 3));                                  // not taken
        append(rtype(3'b010, 1, 2, 3, 1'b0));                  // old load
        append(rtype(3'b011, 1, 2, 3, 1'b0));                  // old store
        append(rtype(3'b101, 1, 2, 3, 1'b1));
        append(rtype(3'b110, 4, 5, 6, 1'b0));
        append(rtype(3'b111, 4, 5, 6, 1'b1));
        append(rtype(isa_pkg::op_arith, 9, 14, 2, 1'b1));
        preload_regs();
        run_program(load_addr - 1'b1);

        // ------------------------------
        // program 2 is a counting loop closed by a backward beq
        model_regs[4] = 16'h0000;
        model_regs[5] = 16'h0001;
        model_regs[6] = 16'h0003;   // trip count
        load_addr = model_pc;
        append(rtype(isa_pkg::op_arith, 4, 5, 4, 1'b0));       // r4 + 1
        append(beq(4, 6, 1));                                  // leave when r4 == r6
        append(beq(0, 0, -3));                                 // always taken
        append(rtype(isa_pkg::op_slt_mult, 4, 6, 7, 1'b0));
        preload_regs();
        run_program(load_addr - 1'b1);

        repeat (3) @(posedge clk);
        if (!pending)
        begin
            $display("** PASS **");
            $finish;
        end
        else
            abort_run("a fetch was issued after the core halted");
    end

endmodule

/* tb.f */
+incdir+dv
source/isa_pkg.sv
source/fetch_ctrl.sv
source/reg_file.sv
source/exec_unit.sv
source/isa_core.sv
dv/tb_isa_core.sv

/* Bender.yml */
package:
  name: isa_core

sources:
  - source/isa_pkg.sv
  - source/fetch_ctrl.sv
  - source/reg_file.sv
  - source/exec_unit.sv
  - source/isa_core.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_isa_core.sv
